//--- build.f
+incdir+rtl
rtl/MipsPkg.sv
rtl/DatapathController.sv
rtl/AluController.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/InstructionMemory.sv
rtl/DataMemory.sv
rtl/ProgramCounter.sv
rtl/MipsCore.sv
verif/MipsCoreTb.sv

//--- rtl/Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu (
    input  MipsPkg::wordT    a,
    input  MipsPkg::wordT    b,
    input  logic [4:0]       shamt,
    input  MipsPkg::aluFuncT aluFunc,
    output MipsPkg::wordT    result,
    output logic             zero
);
    import MipsPkg::*;

    logic signed [63:0] product;
    wordT               diff;

    assign product = $signed(a) * $signed(b);
    assign diff    = a - b;

    always_comb begin
        case (aluFunc)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = diff;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);

            // Compares give 0 or 1
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};

            // Shifts act on b (rt) by the shamt field
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;

            ALU_MUL:  result = product[31:0];  // Low word only
            ALU_SEB:  result = {{24{b[7]}}, b[7:0]};
            ALU_SEH:  result = {{16{b[15]}}, b[15:0]};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- rtl/AluController.sv
`timescale 1ns/1ps
`default_nettype none

module AluController (
    input  MipsPkg::aluOpT   aluOp,
    input  MipsPkg::functT   funct,
    input  logic [4:0]       shamtSel,
    output MipsPkg::aluFuncT aluFunc
);
    import MipsPkg::*;

    always_comb begin
        aluFunc = ALU_ADD;
        case (aluOp)
            AOP_RTYPE: begin
                case (funct)
                    F_ADD, F_ADDU: aluFunc = ALU_ADD;  // No overflow trap
                    F_SUB, F_SUBU: aluFunc = ALU_SUB;
                    F_AND:         aluFunc = ALU_AND;
                    F_OR:          aluFunc = ALU_OR;
                    F_XOR:         aluFunc = ALU_XOR;
                    F_NOR:         aluFunc = ALU_NOR;
                    F_SLT:         aluFunc = ALU_SLT;
                    F_SLTU:        aluFunc = ALU_SLTU;
                    F_SLL:         aluFunc = ALU_SLL;
                    F_SRL:         aluFunc = ALU_SRL;
                    default:       aluFunc = ALU_ADD;
                endcase
            end
            AOP_MUL:   aluFunc = (funct == F_MUL) ? ALU_MUL : ALU_ADD;
            AOP_BSHFL: begin
                // Sub-op lives in the shamt slot
                if (shamtSel == 5'b10000) begin
                    aluFunc = ALU_SEB;
                end else if (shamtSel == 5'b11000) begin
                    aluFunc = ALU_SEH;
                end else begin
                    aluFunc = ALU_OR;
                end
            end
            AOP_ADD, AOP_ADDU: aluFunc = ALU_ADD;
            AOP_SUB:           aluFunc = ALU_SUB;
            AOP_AND:           aluFunc = ALU_AND;
            AOP_OR:            aluFunc = ALU_OR;
            AOP_XOR:           aluFunc = ALU_XOR;
            AOP_SLT:           aluFunc = ALU_SLT;
            AOP_SLTU:          aluFunc = ALU_SLTU;
            default:           aluFunc = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/DataMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module DataMemory (
    input  logic          Clk,
    input  logic          wrEn,
    input  MipsPkg::wordT addr,
    input  MipsPkg::wordT wrData,
    output MipsPkg::wordT rdData
);
    import MipsPkg::*;

    wordT                       mem [0:(2**`DMEM_ADDR_BITS)-1];
    logic [`DMEM_ADDR_BITS-1:0] wordIdx;

    // Word index, upper address bits wrap
    assign wordIdx = addr[`DMEM_ADDR_BITS+1:2];

    always_ff @(posedge Clk) begin
        if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];

endmodule

`default_nettype wire

//--- rtl/DatapathController.sv
`timescale 1ns/1ps
`default_nettype none

module DatapathController (
    input  MipsPkg::opcodeT opCode,
    output logic            regDst,
    output logic            regWrite,
    output logic            aluSrc,
    output logic            memWrite,
    output logic            memRead,
    output logic            branch,
    output logic            branchNe,
    output logic            memToReg,
    output logic            signExt,
    output MipsPkg::aluOpT  aluOp
);
    import MipsPkg::*;

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        regDst   = 1'b0;
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memRead  = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        memToReg = 1'b0;
        signExt  = 1'b0;
        aluOp    = AOP_ADDU;

        case (opCode)
            OP_RTYPE: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                aluOp    = AOP_RTYPE;
            end
            OP_SPECIAL2: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                aluOp    = AOP_MUL;
            end
            OP_SPECIAL3: begin  // Operand is rt, result to rd
                regDst   = 1'b1;
                regWrite = 1'b1;
                aluOp    = AOP_BSHFL;
            end

            ////////////////////////////////
            // Immediate arithmetic
            ////////////////////////////////
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                signExt  = 1'b1;
                case (opCode)
                    OP_ADDI: aluOp = AOP_ADD;
                    OP_SLTI: aluOp = AOP_SLT;
                    OP_SLTIU: aluOp = AOP_SLTU;
                    default: aluOp = AOP_ADDU;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI: begin  // Zero-extended immediate
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (opCode)
                    OP_ANDI: aluOp = AOP_AND;
                    OP_ORI:  aluOp = AOP_OR;
                    default: aluOp = AOP_XOR;
                endcase
            end

            ////////////////////////////////
            // Memory and branches
            ////////////////////////////////
            OP_LW: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                signExt  = 1'b1;
            end
            OP_SW: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                signExt  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                branch   = 1'b1;
                branchNe = (opCode == OP_BNE);
                signExt  = 1'b1;
                aluOp    = AOP_SUB;  // zero flags equality
            end
            default: ;  // Unknown opcode retires as a nop
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/InstructionMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module InstructionMemory (
    input  logic                       Clk,
    input  logic                       rst,
    input  logic                       wrEn,
    input  logic [`IMEM_ADDR_BITS-1:0] wrAddr,
    input  MipsPkg::wordT              wrData,
    input  MipsPkg::wordT              pc,
    output MipsPkg::wordT              instr
);
    import MipsPkg::*;

    wordT                       mem [0:(2**`IMEM_ADDR_BITS)-1];
    logic [`IMEM_ADDR_BITS-1:0] rdIdx;

    // Program load only while the core is held in reset
    always_ff @(posedge Clk) begin
        if (rst && wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    assign rdIdx = pc[`IMEM_ADDR_BITS+1:2];  // Drop byte offset
    assign instr = mem[rdIdx];

endmodule

`default_nettype wire

//--- rtl/MipsCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module MipsCore (
    input  logic                       Clk,
    input  logic                       rst,
    input  logic                       imemWrEn,
    input  logic [`IMEM_ADDR_BITS-1:0] imemAddr,
    input  MipsPkg::wordT              imemWrData,
    output logic                       retireValid,
    output MipsPkg::wordT              retirePc,
    output logic                       wbEn,
    output MipsPkg::regIdxT            wbReg,
    output MipsPkg::wordT              wbData,
    output logic                       stEn,
    output MipsPkg::wordT              stAddr,
    output MipsPkg::wordT              stData
);
    import MipsPkg::*;

    wordT    pc;
    wordT    instr;
    logic    pcRst;
    logic    regDst, regWrite, aluSrc, memWrite, memRead;
    logic    branch, branchNe, memToReg, signExt;
    aluOpT   aluOp;
    aluFuncT aluFunc;
    wordT    rdDataA, rdDataB;
    wordT    immExt;
    wordT    aluB;
    wordT    aluResult;
    logic    aluZero;
    regIdxT  writeReg;
    wordT    dmemRdData;
    wordT    loadData;
    wordT    writeData;

    ////////////////////////////////
    // Retire qualifier
    ////////////////////////////////
    // Low through reset and one cycle after; PC held at 0 meanwhile
    always_ff @(posedge Clk) begin
        if (rst) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= 1'b1;
        end
    end

    assign pcRst = rst || !retireValid;

    ProgramCounter i_pc (
        .Clk(Clk), .rst(pcRst), .branch(branch), .branchNe(branchNe),
        .zero(aluZero), .immExt(immExt), .pc(pc)
    );

    InstructionMemory i_imem (
        .Clk(Clk), .rst(rst), .wrEn(imemWrEn), .wrAddr(imemAddr),
        .wrData(imemWrData), .pc(pc), .instr(instr)
    );

    DatapathController i_ctrl (
        .opCode(opcodeT'(instr[31:26])), .regDst(regDst), .regWrite(regWrite),
        .aluSrc(aluSrc), .memWrite(memWrite), .memRead(memRead), .branch(branch),
        .branchNe(branchNe), .memToReg(memToReg), .signExt(signExt), .aluOp(aluOp)
    );

    AluController i_aluCtrl (
        .aluOp(aluOp), .funct(functT'(instr[5:0])), .shamtSel(instr[10:6]),
        .aluFunc(aluFunc)
    );

    RegisterFile i_regFile (
        .Clk(Clk), .rst(rst), .wrEn(wbEn), .rdAddrA(instr[25:21]),
        .rdAddrB(instr[20:16]), .wrAddr(writeReg), .wrData(writeData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    // Immediate extender, logical immediates zero-extend
    assign immExt = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

    assign writeReg = regDst ? instr[15:11] : instr[20:16];  // rd or rt
    assign aluB     = aluSrc ? immExt : rdDataB;

    Alu i_alu (
        .a(rdDataA), .b(aluB), .shamt(instr[10:6]), .aluFunc(aluFunc),
        .result(aluResult), .zero(aluZero)
    );

    DataMemory i_dmem (
        .Clk(Clk), .wrEn(stEn), .addr(aluResult), .wrData(rdDataB),
        .rdData(dmemRdData)
    );

    ////////////////////////////////
    // Write-back and trace
    ////////////////////////////////
    assign loadData  = memRead ? dmemRdData : '0;
    assign writeData = memToReg ? loadData : aluResult;

    // No state changes until the first valid retire
    assign wbEn   = regWrite && retireValid;
    assign stEn   = memWrite && retireValid;

    assign retirePc = pc;
    assign wbReg    = writeReg;
    assign wbData   = writeData;
    assign stAddr   = aluResult;
    assign stData   = rdDataB;

endmodule

`default_nettype wire

//--- rtl/MipsPkg.sv
`default_nettype none

package MipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    ////////////////////////////////
    // Primary opcodes
    ////////////////////////////////
    typedef enum logic [5:0] {
        OP_RTYPE    = 6'b000000,
        OP_BEQ      = 6'b000100,
        OP_BNE      = 6'b000101,
        OP_ADDI     = 6'b001000,
        OP_ADDIU    = 6'b001001,
        OP_SLTI     = 6'b001010,
        OP_SLTIU    = 6'b001011,
        OP_ANDI     = 6'b001100,
        OP_ORI      = 6'b001101,
        OP_XORI     = 6'b001110,
        OP_SPECIAL2 = 6'b011100,  // mul
        OP_SPECIAL3 = 6'b011111,  // seb, seh
        OP_LW       = 6'b100011,
        OP_SW       = 6'b101011
    } opcodeT;

    // Funct field of the R-type group
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } functT;

    // mul shares its funct code with srl, told apart by opcode
    parameter functT F_MUL = F_SRL;

    // Operation class from the main decoder
    typedef enum logic [3:0] {
        AOP_RTYPE, AOP_ADD, AOP_ADDU, AOP_SUB, AOP_AND, AOP_OR,
        AOP_XOR, AOP_SLT, AOP_SLTU, AOP_MUL, AOP_BSHFL
    } aluOpT;

    // Final ALU operation
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_MUL, ALU_SEB, ALU_SEH
    } aluFuncT;

endpackage

`default_nettype wire

//--- rtl/ProgramCounter.sv
`timescale 1ns/1ps
`default_nettype none

module ProgramCounter (
    input  logic          Clk,
    input  logic          rst,
    input  logic          branch,
    input  logic          branchNe,
    input  logic          zero,
    input  MipsPkg::wordT immExt,
    output MipsPkg::wordT pc
);
    import MipsPkg::*;

    wordT pcPlus4;
    wordT branchTarget;
    logic taken;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign taken        = branch && (zero != branchNe);  // beq on zero, bne on !zero

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= taken ? branchTarget : pcPlus4;
        end
    end

endmodule

`default_nettype wire

//--- rtl/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile (
    input  logic            Clk,
    input  logic            rst,
    input  logic            wrEn,
    input  MipsPkg::regIdxT rdAddrA,
    input  MipsPkg::regIdxT rdAddrB,
    input  MipsPkg::regIdxT wrAddr,
    input  MipsPkg::wordT   wrData,
    output MipsPkg::wordT   rdDataA,
    output MipsPkg::wordT   rdDataB
);
    import MipsPkg::*;

    wordT regs [0:31];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin  // $zero never written
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational reads, $zero forced
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

//--- rtl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////////////////
// Memory geometry
////////////////////////////////

// Word address bits of the instruction ROM (256 words)
`define IMEM_ADDR_BITS 8

// Word address bits of the data memory (256 words)
`define DMEM_ADDR_BITS 8

`endif

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module MipsCoreTb -o MipsCoreTbSim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

simOut=$(./obj_dir/MipsCoreTbSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- verif/MipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module MipsCoreTb;
    import MipsPkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 2;
    localparam int PROG_LEN   = 200;
    localparam int NOP_LEN    = 8;  // Longer than the farthest branch reach
    localparam int BODY_LEN   = PROG_LEN - NOP_LEN;
    localparam logic [31:0] SEED = 32'ha15fa4f0;
    localparam wordT LAST_PC     = 32'((PROG_LEN - 1) * 4);
    // Covers reset, load, one retire per program word and some slack
    localparam int WATCHDOG_NS = (RST_CYCLES + 2 * PROG_LEN + 1 + 20) * CLK_PERIOD;

    logic                       Clk = 1'b0;
    logic                       rst;
    logic                       imemWrEn;
    logic [`IMEM_ADDR_BITS-1:0] imemAddr;
    wordT                       imemWrData;
    logic                       retireValid;
    wordT                       retirePc;
    logic                       wbEn;
    regIdxT                     wbReg;
    wordT                       wbData;
    logic                       stEn;
    wordT                       stAddr;
    wordT                       stData;

    wordT        prog [0:PROG_LEN-1];
    logic [31:0] rngState;
    logic        seenValid;

    // ISA model state
    wordT refRegs [0:31];
    wordT refMem [wordT];
    wordT refPc;

    MipsCore i_dut (
        .Clk(Clk), .rst(rst), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
        .imemWrData(imemWrData), .retireValid(retireValid), .retirePc(retirePc),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .stEn(stEn),
        .stAddr(stAddr), .stData(stData)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    ////////////////////////////////
    // Random program
    ////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic wordT encR(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
                                  input regIdxT rd, input logic [4:0] sh, input logic [5:0] fn);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT encI(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
                                  input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT randomInstr();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] kind;
        logic [15:0] imm;
        logic [15:0] memOff;
        wordT        ins;
        r      = nextRandom();
        r2     = nextRandom();
        imm    = r2[15:0];
        kind   = {16'd0, r2[31:16]} % 32'd26;
        memOff = {9'd0, r[24:20], 2'b00};  // Offsets span 32 words so lw often hits a stored word
        case (kind)
            0:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_ADD);
            1:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_ADDU);
            2:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_SUB);
            3:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_SUBU);
            4:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_AND);
            5:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_OR);
            6:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_XOR);
            7:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_NOR);
            8:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_SLT);
            9:  ins = encR(OP_RTYPE, r[4:0], r[9:5], r[14:10], 5'd0, F_SLTU);
            10: ins = encR(OP_RTYPE, 5'd0, r[9:5], r[14:10], r[19:15], F_SLL);
            11: ins = encR(OP_RTYPE, 5'd0, r[9:5], r[14:10], r[19:15], F_SRL);
            12: ins = encR(OP_SPECIAL2, r[4:0], r[9:5], r[14:10], 5'd0, F_MUL);
            13: ins = encR(OP_SPECIAL3, 5'd0, r[9:5], r[14:10], 5'b10000, 6'b100000);  // seb
            14: ins = encR(OP_SPECIAL3, 5'd0, r[9:5], r[14:10], 5'b11000, 6'b100000);  // seh
            15: ins = encI(OP_ADDI, r[4:0], r[9:5], imm);
            16: ins = encI(OP_ADDIU, r[4:0], r[9:5], imm);
            17: ins = encI(OP_SLTI, r[4:0], r[9:5], imm);
            18: ins = encI(OP_SLTIU, r[4:0], r[9:5], imm);
            19: ins = encI(OP_ANDI, r[4:0], r[9:5], imm);
            20: ins = encI(OP_ORI, r[4:0], r[9:5], imm);
            21: ins = encI(OP_XORI, r[4:0], r[9:5], imm);
            22: ins = encI(OP_LW, 5'd0, r[9:5], memOff);
            23: ins = encI(OP_SW, 5'd0, r[9:5], memOff);
            // Same register on both sides now and then so beq gets taken
            24: ins = encI(OP_BEQ, r[4:0], r[25] ? r[4:0] : r[9:5], {14'd0, r[27:26]} + 16'd1);
            default: ins = encI(OP_BNE, r[4:0], r[25] ? r[4:0] : r[9:5],
                                {14'd0, r[27:26]} + 16'd1);
        endcase
        return ins;
    endfunction

    ////////////////////////////////
    // ISA reference model
    ////////////////////////////////
    function automatic void resetModel();
        int i;
        for (i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        refMem.delete();
        refPc = '0;
    endfunction

    // Retires one instruction in the model and returns its visible effects
    function automatic void stepRef(input wordT ins, output logic expWb, output regIdxT expReg,
                                    output wordT expWbData, output logic expSt,
                                    output wordT expStAddr, output wordT expStData);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sh;
        wordT       a;
        wordT       b;
        wordT       sImm;
        wordT       zImm;
        wordT       addr;
        wordT       nextPc;
        op        = ins[31:26];
        fn        = ins[5:0];
        sh        = ins[10:6];
        a         = refRegs[ins[25:21]];
        b         = refRegs[ins[20:16]];
        sImm      = {{16{ins[15]}}, ins[15:0]};
        zImm      = {16'h0000, ins[15:0]};
        addr      = a + sImm;
        nextPc    = refPc + 32'd4;
        expWb     = 1'b0;
        expReg    = ins[20:16];
        expWbData = '0;
        expSt     = 1'b0;
        expStAddr = '0;
        expStData = '0;
        case (op)
            6'b000000: begin  // SPECIAL
                expWb  = 1'b1;
                expReg = ins[15:11];
                case (fn)
                    6'b100000, 6'b100001: expWbData = a + b;  // Overflow wraps
                    6'b100010, 6'b100011: expWbData = a - b;
                    6'b100100: expWbData = a & b;
                    6'b100101: expWbData = a | b;
                    6'b100110: expWbData = a ^ b;
                    6'b100111: expWbData = ~(a | b);
                    6'b101010: expWbData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'b101011: expWbData = (a < b) ? 32'd1 : 32'd0;
                    6'b000000: expWbData = b << sh;
                    6'b000010: expWbData = b >> sh;
                    default:   expWbData = '0;
                endcase
            end
            6'b011100: begin
                expWb     = 1'b1;
                expReg    = ins[15:11];
                expWbData = a * b;  // Low word equal for signed and unsigned
            end
            6'b011111: begin
                expWb     = 1'b1;
                expReg    = ins[15:11];
                expWbData = (sh == 5'b10000) ? {{24{b[7]}}, b[7:0]} : {{16{b[15]}}, b[15:0]};
            end
            6'b001000, 6'b001001: begin
                expWb     = 1'b1;
                expWbData = a + sImm;
            end
            6'b001010: begin
                expWb     = 1'b1;
                expWbData = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            end
            6'b001011: begin
                expWb     = 1'b1;
                expWbData = (a < sImm) ? 32'd1 : 32'd0;
            end
            6'b001100: begin
                expWb     = 1'b1;
                expWbData = a & zImm;
            end
            6'b001101: begin
                expWb     = 1'b1;
                expWbData = a | zImm;
            end
            6'b001110: begin
                expWb     = 1'b1;
                expWbData = a ^ zImm;
            end
            6'b100011: begin  // lw
                expWb     = 1'b1;
                expWbData = refMem.exists(addr) ? refMem[addr] : 'x;
            end
            6'b101011: begin  // sw
                expSt        = 1'b1;
                expStAddr    = addr;
                expStData    = b;
                refMem[addr] = b;
            end
            6'b000100: if (a == b) nextPc = nextPc + (sImm << 2);
            6'b000101: if (a != b) nextPc = nextPc + (sImm << 2);
            default: ;
        endcase
        if (expWb && expReg != 5'd0) begin
            refRegs[expReg] = expWbData;
        end
        refPc = nextPc;
    endfunction

    task automatic buildProgram();
        int     i;
        wordT   ins;
        logic   wb;
        regIdxT wr;
        wordT   wd;
        logic   st;
        wordT   sa;
        wordT   sd;
        resetModel();
        for (i = 0; i < PROG_LEN; i++) begin
            ins = (i < BODY_LEN) ? randomInstr() : '0;
            // Load from a word never stored becomes an addiu
            if (ins[31:26] == OP_LW && !refMem.exists({{16{ins[15]}}, ins[15:0]})) begin
                ins = encI(OP_ADDIU, 5'd0, ins[20:16], ins[15:0]);
            end
            prog[i] = ins;
            if (refPc == (wordT'(i) << 2)) begin  // Only words on the executed path
                stepRef(ins, wb, wr, wd, st, sa, sd);
            end
        end
    endtask

    ////////////////////////////////
    // Checks
    ////////////////////////////////
    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkPc(input wordT got, input wordT exp);
        if (got !== exp) begin
            reportFailure($sformatf("mismatch retirePc: got %h expected %h", got, exp));
        end
    endtask

    task automatic checkWriteback(input logic gotEn, input regIdxT gotReg, input wordT gotData,
                                  input logic expEn, input regIdxT expReg, input wordT expData);
        if (gotEn !== expEn) begin
            reportFailure($sformatf("mismatch wbEn: got %h expected %h", gotEn, expEn));
        end else if (expEn && gotReg !== expReg) begin
            reportFailure($sformatf("mismatch wbReg: got %h expected %h", gotReg, expReg));
        end else if (expEn && gotData !== expData) begin
            reportFailure($sformatf("mismatch wbData: got %h expected %h", gotData, expData));
        end
    endtask

    task automatic checkStore(input logic gotEn, input wordT gotAddr, input wordT gotData,
                              input logic expEn, input wordT expAddr, input wordT expData);
        if (gotEn !== expEn) begin
            reportFailure($sformatf("mismatch stEn: got %h expected %h", gotEn, expEn));
        end else if (expEn && gotAddr !== expAddr) begin
            reportFailure($sformatf("mismatch stAddr: got %h expected %h", gotAddr, expAddr));
        end else if (expEn && gotData !== expData) begin
            reportFailure($sformatf("mismatch stData: got %h expected %h", gotData, expData));
        end
    endtask

    // Stimulus changes only on falling edges
    initial begin
        int i;
        rst        = 1'b1;
        imemWrEn   = 1'b0;
        imemAddr   = '0;
        imemWrData = '0;
        seenValid  = 1'b0;
        rngState   = SEED;
        buildProgram();
        resetModel();
        repeat (RST_CYCLES) @(negedge Clk);
        for (i = 0; i < PROG_LEN; i++) begin
            @(negedge Clk);
            imemWrEn   <= 1'b1;
            imemAddr   <= i[`IMEM_ADDR_BITS-1:0];
            imemWrData <= prog[i];
        end
        @(negedge Clk);
        imemWrEn <= 1'b0;
        rst      <= 1'b0;
    end

    always @(negedge Clk) begin
        if (rst === 1'b1 && (wbEn !== 1'b0 || stEn !== 1'b0 || retireValid !== 1'b0)) begin
            reportFailure("write enable or retireValid active while rst is high");
        end
    end

    always @(negedge Clk) begin
        logic   expWb;
        regIdxT expReg;
        wordT   expWbData;
        logic   expSt;
        wordT   expStAddr;
        wordT   expStData;
        wordT   curPc;
        if (retireValid === 1'b1) begin
            seenValid = 1'b1;
            curPc     = refPc;
            checkPc(retirePc, curPc);
            stepRef(prog[curPc[9:2]], expWb, expReg, expWbData, expSt, expStAddr, expStData);
            checkWriteback(wbEn, wbReg, wbData, expWb, expReg, expWbData);
            checkStore(stEn, stAddr, stData, expSt, expStAddr, expStData);
            if (curPc == LAST_PC) begin  // Last nop retired
                $display("test passed");
                $finish;
            end
        end else if (seenValid) begin
            reportFailure("retireValid dropped after the first retire");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        reportFailure("timeout before program end");
    end

endmodule

`default_nettype wire
